//--- flist.f
verilog/cache_types_pkg.sv
verilog/cache_control.sv
verilog/way_store.sv
verilog/hit_compare.sv
verilog/plru_tree.sv
verilog/line_merge.sv
verilog/cache_top.sv
tb/mem_model.sv
tb/cache_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = cache_tb
FLIST     = flist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb/cache_tb.sv
module cache_tb;
    import cache_types_pkg::*;

    localparam int SETS         = 16;
    localparam int MEM_LATENCY  = 3;
    localparam int MEM_BYTES    = 8192;
    localparam int NUM_ACCESSES = 220;
    localparam int TIMEOUT      = NUM_ACCESSES * (2 * MEM_LATENCY + 8) + 200;

    logic     clk;
    logic     reset;
    logic     cpu_valid;
    cpu_req_t cpu_req;
    logic     cpu_resp;
    word_t    cpu_rdata;
    logic     mem_read;
    logic     mem_write;
    mem_req_t mem_req;
    logic     mem_resp;
    line_t    mem_rdata;
    int       read_count;
    int       write_count;

    int         error_count = 0;
    int         cycle_count = 0;
    logic [7:0] ref_mem [MEM_BYTES];

    cache_top #(.SETS(SETS)) DUT (
        .clk       (clk),
        .reset     (reset),
        .cpu_valid (cpu_valid),
        .cpu_req   (cpu_req),
        .cpu_resp  (cpu_resp),
        .cpu_rdata (cpu_rdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_req   (mem_req),
        .mem_resp  (mem_resp),
        .mem_rdata (mem_rdata)
    );

    mem_model #(.MEM_LATENCY(MEM_LATENCY), .LINES(256)) u_mem (
        .clk         (clk),
        .reset       (reset),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_req     (mem_req),
        .mem_resp    (mem_resp),
        .mem_rdata   (mem_rdata),
        .read_count  (read_count),
        .write_count (write_count)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT) begin
            $display("Timeout: the cache did not answer within %0d cycles", TIMEOUT);
            $display("Test failures found");
            $fatal(1, "simulation stopped by the watchdog");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1, "value mismatch");
        end
    endtask

    // Initial memory image, every address bit takes part
    function automatic logic [7:0] fill_byte(input int a);
        return 8'((a * 13) ^ (a >> 8) ^ 8'ha5);
    endfunction

    function automatic logic [31:0] make_addr(input int set, input int tag, input int word);
        return 32'((tag * SETS + set) * 32 + word * 4);
    endfunction

    function automatic word_t ref_word(input logic [31:0] addr);
        logic [12:0] base;
        word_t       w;
        base = {addr[12:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = ref_mem[base + 13'(b)];
        end
        return w;
    endfunction

    function automatic line_t ref_line(input logic [7:0] idx);
        logic [12:0] base;
        line_t       l;
        base = {idx, 5'b00000};
        for (int b = 0; b < 32; b++) begin
            l[8*b +: 8] = ref_mem[base + 13'(b)];
        end
        return l;
    endfunction

    task automatic apply_store(input logic [31:0] addr, input word_t wdata, input wmask_t wmask);
        logic [12:0] base;
        base = {addr[12:2], 2'b00};
        for (int b = 0; b < 4; b++) begin
            if (wmask[b]) begin
                ref_mem[base + 13'(b)] = wdata[8*b +: 8];
            end
        end
    endtask

    // Tree rule: path bits point away from the used way
    function automatic plru_t tree_touch(input plru_t t, input way_t w);
        plru_t n;
        n = t;
        n[0] = (w < 2) ? 1'b1 : 1'b0;
        if (w == 2'd0) n[1] = 1'b1;
        if (w == 2'd1) n[1] = 1'b0;
        if (w == 2'd2) n[2] = 1'b1;
        if (w == 2'd3) n[2] = 1'b0;
        return n;
    endfunction

    function automatic way_t tree_victim(input plru_t t);
        if (t[0] == 1'b0) begin
            return t[1] ? 2'd1 : 2'd0;
        end
        return t[2] ? 2'd3 : 2'd2;
    endfunction

    // Edges counts rising edges between request and response cycle
    task automatic cpu_access(input logic [31:0] addr, input word_t wdata, input wmask_t wmask,
                              output word_t rdata, output int edges);
        cpu_valid     = 1'b1;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        cpu_req.wmask = wmask;
        edges = 0;
        @(negedge clk);
        while (!cpu_resp) begin
            @(posedge clk);
            edges++;
            @(negedge clk);
        end
        rdata = cpu_rdata;
        @(posedge clk);
        #1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
    endtask

    task automatic reset_and_first_miss();
        logic [31:0] addr;
        word_t       rdata;
        int          edges;
        int          rc;
        check("reset_state cpu_resp", 0, 32'(cpu_resp));
        check("reset_state mem_read", 0, 32'(mem_read));
        check("reset_state mem_write", 0, 32'(mem_write));
        rc   = read_count;
        addr = make_addr(2, 1, 3);
        cpu_access(addr, '0, '0, rdata, edges);
        check("reset_state read data", ref_word(addr), rdata);
        check("reset_state read count", rc + 1, read_count);
    endtask

    task automatic hit_after_miss();
        logic [31:0] addr;
        word_t       rdata;
        int          edges;
        int          rc;
        rc   = read_count;
        addr = make_addr(2, 1, 5);
        cpu_access(addr, '0, '0, rdata, edges);
        check("hit_after_miss read data", ref_word(addr), rdata);
        check("hit_after_miss read count", rc, read_count);
        check("hit_after_miss latency", 1, edges);
    endtask

    task automatic store_hit_merge();
        logic [31:0] addr;
        word_t       rdata;
        word_t       wd;
        int          edges;
        int          rc;
        int          wc;
        rc   = read_count;
        wc   = write_count;
        addr = make_addr(2, 1, 5);
        wd   = $urandom;
        cpu_access(addr, wd, 4'b0101, rdata, edges);
        apply_store(addr, wd, 4'b0101);
        cpu_access(addr, '0, '0, rdata, edges);
        check("store_hit_merge read data", ref_word(addr), rdata);
        check("store_hit_merge read count", rc, read_count);
        check("store_hit_merge write count", wc, write_count);
    endtask

    task automatic dirty_eviction();
        logic [31:0] addr;
        word_t       rdata;
        word_t       wd;
        wmask_t      mask;
        plru_t       tree;
        line_t       mem_line;
        line_t       exp_line;
        int          edges;
        int          wc;
        int          victim_tag;
        tree = '0;
        for (int t = 1; t <= 4; t++) begin
            addr = make_addr(5, t, t);
            wd   = $urandom;
            mask = 4'($urandom % 15 + 1);
            cpu_access(addr, wd, mask, rdata, edges);
            apply_store(addr, wd, mask);
            // Ways fill lowest first while invalid ones remain
            tree = tree_touch(tree, way_t'(t - 1));
        end
        victim_tag = int'(tree_victim(tree)) + 1;
        wc   = write_count;
        addr = make_addr(5, 5, 0);
        wd   = $urandom;
        cpu_access(addr, wd, 4'b1111, rdata, edges);
        apply_store(addr, wd, 4'b1111);
        check("dirty_eviction write count", wc + 1, write_count);
        mem_line = u_mem.peek_line(8'(victim_tag * SETS + 5));
        exp_line = ref_line(8'(victim_tag * SETS + 5));
        for (int w = 0; w < 8; w++) begin
            check("dirty_eviction memory line", exp_line[32*w +: 32], mem_line[32*w +: 32]);
        end
        addr = make_addr(5, victim_tag, victim_tag);
        cpu_access(addr, '0, '0, rdata, edges);
        check("dirty_eviction reread data", ref_word(addr), rdata);
    endtask

    task automatic replacement_order();
        logic [31:0] addr;
        word_t       rdata;
        plru_t       tree;
        int          edges;
        int          rc;
        int          victim_tag;
        tree = '0;
        // Tags 1 to 4 are lines A to D, tag 5 is line E
        for (int t = 1; t <= 4; t++) begin
            addr = make_addr(9, t, 0);
            cpu_access(addr, '0, '0, rdata, edges);
            check("replacement_order fill data", ref_word(addr), rdata);
            tree = tree_touch(tree, way_t'(t - 1));
        end
        addr = make_addr(9, 1, 1);
        cpu_access(addr, '0, '0, rdata, edges);
        tree = tree_touch(tree, 2'd0);
        victim_tag = int'(tree_victim(tree)) + 1;
        addr = make_addr(9, 5, 2);
        cpu_access(addr, '0, '0, rdata, edges);
        check("replacement_order new line data", ref_word(addr), rdata);
        for (int t = 1; t <= 4; t++) begin
            if (t != victim_tag) begin
                rc   = read_count;
                addr = make_addr(9, t, 3);
                cpu_access(addr, '0, '0, rdata, edges);
                check("replacement_order survivor read count", rc, read_count);
                check("replacement_order survivor data", ref_word(addr), rdata);
            end
        end
        rc   = read_count;
        addr = make_addr(9, victim_tag, 4);
        cpu_access(addr, '0, '0, rdata, edges);
        check("replacement_order victim read count", rc + 1, read_count);
        check("replacement_order victim data", ref_word(addr), rdata);
    endtask

    task automatic random_mix();
        logic [31:0] addr;
        word_t       rdata;
        word_t       wd;
        wmask_t      mask;
        int          edges;
        for (int i = 0; i < 200; i++) begin
            addr = make_addr(12 + int'($urandom % 3), int'($urandom % 8), int'($urandom % 8));
            if ($urandom % 2 == 0) begin
                cpu_access(addr, '0, '0, rdata, edges);
                check("random_mix read data", ref_word(addr), rdata);
            end else begin
                wd   = $urandom;
                mask = 4'($urandom % 15 + 1);
                cpu_access(addr, wd, mask, rdata, edges);
                apply_store(addr, wd, mask);
            end
        end
    endtask

    initial begin
        void'($urandom(32'h90a4));
        reset     = 1'b1;
        cpu_valid = 1'b0;
        cpu_req   = '0;
        for (int a = 0; a < MEM_BYTES; a++) begin
            ref_mem[13'(a)] = fill_byte(a);
        end
        for (int i = 0; i < 256; i++) begin
            u_mem.load_line(8'(i), ref_line(8'(i)));
        end
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_and_first_miss();
        hit_after_miss();
        store_hit_merge();
        dirty_eviction();
        replacement_order();
        random_mix();

        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule : cache_tb

//--- tb/mem_model.sv
module mem_model #(
    parameter int MEM_LATENCY = 3,
    parameter int LINES       = 256
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  cache_types_pkg::mem_req_t mem_req,
    output logic                      mem_resp,
    output cache_types_pkg::line_t    mem_rdata,
    output int                        read_count,
    output int                        write_count
);
    import cache_types_pkg::*;

    localparam int SLOT_W = $clog2(LINES);

    line_t             lines [LINES];
    int                wait_cnt;
    logic [SLOT_W-1:0] slot;

    assign slot = mem_req.line_addr[SLOT_W-1:0];

    task automatic load_line(input logic [SLOT_W-1:0] idx, input line_t data);
        lines[idx] = data;
    endtask

    function automatic line_t peek_line(input logic [SLOT_W-1:0] idx);
        return lines[idx];
    endfunction

    // Answer after MEM_LATENCY cycles of a held request, one-cycle pulse
    always @(posedge clk) begin
        if (reset) begin
            mem_resp    <= 1'b0;
            mem_rdata   <= '0;
            wait_cnt    <= 0;
            read_count  <= 0;
            write_count <= 0;
        end else if (mem_resp) begin
            mem_resp <= 1'b0;
            wait_cnt <= 0;
        end else if (mem_read || mem_write) begin
            if (wait_cnt == MEM_LATENCY - 1) begin
                mem_resp <= 1'b1;
                if (mem_write) begin
                    lines[slot] = mem_req.wdata;
                    write_count <= write_count + 1;
                end else begin
                    mem_rdata  <= lines[slot];
                    read_count <= read_count + 1;
                end
            end else begin
                wait_cnt <= wait_cnt + 1;
            end
        end
    end

endmodule : mem_model

//--- verilog/cache_top.sv
module cache_top #(
    parameter int SETS = 16
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       cpu_valid,
    input  cache_types_pkg::cpu_req_t  cpu_req,
    output logic                       cpu_resp,
    output cache_types_pkg::word_t     cpu_rdata,
    output logic                       mem_read,
    output logic                       mem_write,
    output cache_types_pkg::mem_req_t  mem_req,
    input  logic                       mem_resp,
    input  cache_types_pkg::line_t     mem_rdata
);
    import cache_types_pkg::*;

    localparam int IDX_W = $clog2(SETS);

    line_addr_t                req_line_addr;
    logic [IDX_W-1:0]          index;
    logic [2:0]                word_sel;
    logic                      cpu_write;
    cache_state_t              state;
    logic                      hit;
    logic                      victim_dirty;
    logic                      fill_we;
    logic                      store_we;
    logic                      plru_we;
    way_t                      hit_way;
    way_t                      victim_way;
    way_t                      wr_way;
    logic [WAYS-1:0]           valid;
    logic [WAYS-1:0]           dirty;
    line_addr_t [WAYS-1:0]     tags;
    line_t [WAYS-1:0]          lines;
    line_t                     hit_line;
    line_t                     base_line;
    line_t                     merged_line;

    // Address split into line address, set index and word select
    assign req_line_addr = cpu_req.addr[31:5];
    assign index         = req_line_addr[IDX_W-1:0];
    assign word_sel      = cpu_req.addr[4:2];
    assign cpu_write     = |cpu_req.wmask;

    assign victim_dirty = valid[victim_way] & dirty[victim_way];
    assign wr_way       = store_we ? hit_way : victim_way;
    assign base_line    = (state == allocate_s) ? mem_rdata : hit_line;

    assign mem_req.line_addr = (state == writeback_s) ? tags[victim_way] : req_line_addr;
    assign mem_req.wdata     = lines[victim_way];

    cache_control u_control (
        .clk          (clk),
        .reset        (reset),
        .cpu_valid    (cpu_valid),
        .cpu_write    (cpu_write),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .mem_resp     (mem_resp),
        .state        (state),
        .cpu_resp     (cpu_resp),
        .mem_read     (mem_read),
        .mem_write    (mem_write),
        .fill_we      (fill_we),
        .store_we     (store_we),
        .plru_we      (plru_we)
    );

    way_store #(.SETS(SETS)) u_ways (
        .clk      (clk),
        .reset    (reset),
        .index    (index),
        .fill_we  (fill_we),
        .store_we (store_we),
        .wr_way   (wr_way),
        .wr_line  (merged_line),
        .wr_tag   (req_line_addr),
        .wr_dirty (cpu_write),
        .valid    (valid),
        .dirty    (dirty),
        .tags     (tags),
        .lines    (lines)
    );

    hit_compare u_compare (
        .req_line_addr (req_line_addr),
        .word_sel      (word_sel),
        .valid         (valid),
        .tags          (tags),
        .lines         (lines),
        .hit           (hit),
        .hit_way       (hit_way),
        .hit_line      (hit_line),
        .rdata         (cpu_rdata)
    );

    plru_tree #(.SETS(SETS)) u_plru (
        .clk        (clk),
        .reset      (reset),
        .index      (index),
        .plru_we    (plru_we),
        .used_way   (hit_way),
        .valid      (valid),
        .victim_way (victim_way)
    );

    line_merge u_merge (
        .base_line   (base_line),
        .word_sel    (word_sel),
        .wdata       (cpu_req.wdata),
        .wmask       (cpu_req.wmask),
        .merged_line (merged_line)
    );

endmodule : cache_top

//--- verilog/line_merge.sv
module line_merge (
    input  cache_types_pkg::line_t  base_line,
    input  logic [2:0]              word_sel,
    input  cache_types_pkg::word_t  wdata,
    input  cache_types_pkg::wmask_t wmask,
    output cache_types_pkg::line_t  merged_line
);
    import cache_types_pkg::*;

    localparam int WORDS = $bits(line_t) / $bits(word_t);
    localparam int BYTES = $bits(word_t) / 8;

    word_t [WORDS-1:0] words;

    // Only masked bytes of the selected word change
    always_comb begin
        words = base_line;
        for (int b = 0; b < BYTES; b++) begin
            if (wmask[b]) begin
                words[word_sel][8*b +: 8] = wdata[8*b +: 8];
            end
        end
    end

    assign merged_line = words;

endmodule : line_merge

//--- verilog/plru_tree.sv
module plru_tree #(
    parameter int SETS = 16
) (
    input  logic                             clk,
    input  logic                             reset,
    input  logic [$clog2(SETS)-1:0]          index,
    input  logic                             plru_we,
    input  cache_types_pkg::way_t            used_way,
    input  logic [cache_types_pkg::WAYS-1:0] valid,
    output cache_types_pkg::way_t            victim_way
);
    import cache_types_pkg::*;

    plru_t tree_mem [SETS];
    plru_t cur;
    plru_t updated;

    assign cur = tree_mem[index];

    always_comb begin
        victim_way = cur[0] ? {1'b1, cur[2]} : {1'b0, cur[1]};
        // Invalid ways first, lowest number first
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim_way = way_t'(w);
            end
        end
    end

    // Point the path bits away from the used way
    always_comb begin
        updated    = cur;
        updated[0] = ~used_way[1];
        if (used_way[1]) begin
            updated[2] = ~used_way[0];
        end else begin
            updated[1] = ~used_way[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                tree_mem[s] <= '0;
            end
        end else if (plru_we) begin
            tree_mem[index] <= updated;
        end
    end

endmodule : plru_tree

//--- verilog/hit_compare.sv
module hit_compare (
    input  cache_types_pkg::line_addr_t                            req_line_addr,
    input  logic [2:0]                                             word_sel,
    input  logic [cache_types_pkg::WAYS-1:0]                       valid,
    input  cache_types_pkg::line_addr_t [cache_types_pkg::WAYS-1:0] tags,
    input  cache_types_pkg::line_t [cache_types_pkg::WAYS-1:0]     lines,
    output logic                                                   hit,
    output cache_types_pkg::way_t                                  hit_way,
    output cache_types_pkg::line_t                                 hit_line,
    output cache_types_pkg::word_t                                 rdata
);
    import cache_types_pkg::*;

    localparam int WORDS = $bits(line_t) / $bits(word_t);

    logic [WAYS-1:0]        match;
    word_t [WORDS-1:0]      line_words;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            match[w] = valid[w] && (tags[w] == req_line_addr);
        end
    end

    // At most one way matches, lowest wins anyway
    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit      = |match;
    assign hit_line = lines[hit_way];

    // Word view of the hitting line
    assign line_words = hit_line;
    assign rdata      = line_words[word_sel];

endmodule : hit_compare

//--- verilog/way_store.sv
module way_store #(
    parameter int SETS = 16
) (
    input  logic                                                 clk,
    input  logic                                                 reset,
    input  logic [$clog2(SETS)-1:0]                              index,
    input  logic                                                 fill_we,
    input  logic                                                 store_we,
    input  cache_types_pkg::way_t                                wr_way,
    input  cache_types_pkg::line_t                               wr_line,
    input  cache_types_pkg::line_addr_t                          wr_tag,
    input  logic                                                 wr_dirty,
    output logic [cache_types_pkg::WAYS-1:0]                     valid,
    output logic [cache_types_pkg::WAYS-1:0]                     dirty,
    output cache_types_pkg::line_addr_t [cache_types_pkg::WAYS-1:0] tags,
    output cache_types_pkg::line_t [cache_types_pkg::WAYS-1:0]   lines
);
    import cache_types_pkg::*;

    logic [WAYS-1:0] valid_mem [SETS];
    logic [WAYS-1:0] dirty_mem [SETS];
    line_addr_t      tag_mem   [SETS][WAYS];
    line_t           line_mem  [SETS][WAYS];

    // Status bits
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else if (fill_we) begin
            valid_mem[index][wr_way] <= 1'b1;
            dirty_mem[index][wr_way] <= wr_dirty;
        end else if (store_we) begin
            dirty_mem[index][wr_way] <= 1'b1;
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[index][wr_way] <= wr_tag;
        end
        if (fill_we || store_we) begin
            line_mem[index][wr_way] <= wr_line;
        end
    end

    assign valid = valid_mem[index];
    assign dirty = dirty_mem[index];

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            tags[w]  = tag_mem[index][w];
            lines[w] = line_mem[index][w];
        end
    end

endmodule : way_store

//--- verilog/cache_control.sv
module cache_control (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cpu_valid,
    input  logic                          cpu_write,
    input  logic                          hit,
    input  logic                          victim_dirty,
    input  logic                          mem_resp,
    output cache_types_pkg::cache_state_t state,
    output logic                          cpu_resp,
    output logic                          mem_read,
    output logic                          mem_write,
    output logic                          fill_we,
    output logic                          store_we,
    output logic                          plru_we
);
    import cache_types_pkg::*;

    cache_state_t next_state;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle_s;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        cpu_resp   = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        fill_we    = 1'b0;
        store_we   = 1'b0;
        plru_we    = 1'b0;

        case (state)
            idle_s: begin
                if (cpu_valid) begin
                    next_state = compare_s;
                end
            end

            compare_s: begin
                if (hit) begin
                    // Respond, touch the tree, commit a store
                    cpu_resp   = 1'b1;
                    plru_we    = 1'b1;
                    store_we   = cpu_write;
                    next_state = idle_s;
                end else if (victim_dirty) begin
                    next_state = writeback_s;
                end else begin
                    next_state = allocate_s;
                end
            end

            writeback_s: begin
                mem_write = 1'b1;
                if (mem_resp) begin
                    next_state = allocate_s;
                end
            end

            allocate_s: begin
                mem_read = 1'b1;
                if (mem_resp) begin
                    // Install fetched line, then retry as a hit
                    fill_we    = 1'b1;
                    next_state = compare_s;
                end
            end

            default: begin
                next_state = idle_s;
            end
        endcase
    end

endmodule : cache_control

//--- verilog/cache_types_pkg.sv
package cache_types_pkg;

    // Associativity is fixed by the 3-bit PLRU tree
    localparam int WAYS = 4;

    // CPU side data word and its byte write mask
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wmask_t;

    // One cache line, 32 bytes
    typedef logic [255:0] line_t;

    // Byte address without the 5 offset bits, also stored as the tag
    typedef logic [26:0] line_addr_t;

    typedef logic [1:0] way_t;

    // Bit 0 root, bit 1 picks within ways 0-1, bit 2 within ways 2-3
    typedef logic [2:0] plru_t;

    typedef struct packed {
        logic [31:0] addr;
        word_t       wdata;
        wmask_t      wmask;
    } cpu_req_t;

    typedef struct packed {
        line_addr_t line_addr;
        line_t      wdata;
    } mem_req_t;

    typedef enum logic [1:0] {
        idle_s,
        compare_s,
        writeback_s,
        allocate_s
    } cache_state_t;

endpackage : cache_types_pkg
